//--- Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/instr_decode.sv
      - verilog/alu_execute.sv
      - verilog/result_queue.sv
      - verilog/cpu_core.sv
  - target: test
    files:
      - test/cpu_core_props.sv
      - test/tb_cpu_core.sv

//--- filelist.f
verilog/cpu_pkg.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/result_queue.sv
verilog/cpu_core.sv
test/cpu_core_props.sv
test/tb_cpu_core.sv

//--- test/cpu_core_props.sv
// Concurrent checks on the credit loops, halt and reset state of cpu_core.
// Bound into every cpu_core instance by the statement at the end of this file.

`timescale 1ns/10ps

module cpu_core_props #(
	parameter int RES_DEPTH = 4
) (
	input logic clk_sys,
	input logic rst_n,
	input logic instr_valid,
	input logic instr_credit,
	input logic res_valid,
	input logic res_credit,
	input logic halted
);

	import cpu_pkg::*;

	int in_cred;	// Sender credits held
	int out_cred;	// Queue credits toward the receiver
	int fail_cnt = 0;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			in_cred  <= IN_DEPTH;
			out_cred <= RES_DEPTH;
		end else begin
			in_cred  <= in_cred - int'(instr_valid) + int'(instr_credit);
			out_cred <= out_cred - int'(res_valid) + int'(res_credit);
		end
	end

	a_send_credit: assert property (@(posedge clk_sys) disable iff (!rst_n)
		instr_valid |-> in_cred > 0)
		else begin $error("Word sent with no input credit"); fail_cnt++; end

	a_credit_return: assert property (@(posedge clk_sys) disable iff (!rst_n)
		instr_credit |-> in_cred < IN_DEPTH)
		else begin $error("instr_credit with no word outstanding"); fail_cnt++; end

	a_res_credit: assert property (@(posedge clk_sys) disable iff (!rst_n)
		res_valid |-> out_cred > 0)
		else begin $error("res_valid with no receiver credit"); fail_cnt++; end

	a_reset_state: assert property (@(posedge clk_sys)
		!rst_n |=> !res_valid && !instr_credit && !halted)
		else begin $error("Outputs active after reset"); fail_cnt++; end

	a_halt_no_credit: assert property (@(posedge clk_sys) disable iff (!rst_n)
		halted |-> !instr_credit)
		else begin $error("instr_credit while halted"); fail_cnt++; end

endmodule

bind cpu_core cpu_core_props #(.RES_DEPTH(RES_DEPTH)) props_i (.*);

//--- test/tb_cpu_core.sv
// Testbench for cpu_core. Feeds directed and random instruction words through
// the input credit loop and predicts every result record with a register and
// flag model. Records are checked in order as they leave the core.
// Ends with one line per test and a closing count line.

`timescale 1ns/10ps

module tb_cpu_core;

	import cpu_pkg::*;

	localparam int RES_DEPTH    = 4;
	localparam int N_RAND       = 40;	// Random words per test
	localparam int N_WORDS      = 8 * N_RAND + 40;	// Bound on words sent over all tests
	localparam int WD_CYCLES    = 40 * N_WORDS + 1000;
	localparam int DRAIN_CYCLES = 4000;

	logic        clk_sys = 1'b0;
	logic        rst_n;
	logic        user_mode;
	logic        instr_valid;
	instr_word_t instr;
	logic        instr_credit;
	logic        res_valid;
	result_rec_t res;
	logic        res_credit;
	logic        halted;

	logic [31:0] stim_seed = 32'h830cc080;	// Stimulus stream
	logic [31:0] rx_seed   = 32'h830cc080;	// Receiver stream
	logic [15:0] mregs [1:7];	// Model r1-r7
	flags_t      mflags;	// Model R0
	logic        mhalted;
	result_rec_t exp_q [$];	// Predicted records in order
	int          sent;
	int          credits_back;
	int          owed;	// Records taken whose credit is not yet returned
	logic        bp_mode;	// Receiver holds credits back
	logic        quiet;	// Set while the stopped core must stay still
	int          err_cnt;
	int          rec_cnt;
	int          err0;
	int          rec0;
	int          tests;
	logic [5:0]  logic_ops [6] = '{OP_LW, OP_LWT, OP_OR, OP_NR, OP_ER, OP_XR};
	logic [5:0]  arith_ops [4] = '{OP_AW, OP_AWT, OP_AC, OP_SW};
	logic [5:0]  cmp_ops   [2] = '{OP_CW, OP_CWT};
	logic [5:0]  norm_ops  [9] = '{OP_LW, OP_AW, OP_AC, OP_SW, OP_CW, OP_OR, OP_NR, OP_ER, OP_XR};

	always #10 clk_sys = ~clk_sys;

	cpu_core #(.RES_DEPTH(RES_DEPTH)) dut_i (.*);

	function automatic logic [31:0] lcg_step(inout logic [31:0] s);
		s = s * 32'd1664525 + 32'd1013904223;
		return s;
	endfunction

	function automatic int next_rand(input int n);	// 0 to n-1
		return int'(lcg_step(stim_seed) >> 16) % n;
	endfunction

	function automatic logic [15:0] reg_value(input logic [2:0] idx);
		return (idx == 3'd0) ? {9'd0, mflags} : mregs[idx];	// Index 0 is R0
	endfunction

	function automatic instr_word_t normal_word(input logic [5:0] opc, input int ra, input int rc);
		instr_word_t w;
		w.fmt_normal.opcode = opc;
		w.fmt_normal.d      = 1'b0;
		w.fmt_normal.ra     = 3'(ra);
		w.fmt_normal.rb     = 3'd0;
		w.fmt_normal.rc     = 3'(rc);
		return w;
	endfunction

	function automatic instr_word_t short_word(input logic [5:0] opc, input int ra, input int t);
		instr_word_t w;
		w.fmt_short.opcode = opc;
		w.fmt_short.t_sign = (t < 0);
		w.fmt_short.ra     = 3'(ra);
		w.fmt_short.t_mag  = 6'((t < 0) ? -t : t);
		return w;
	endfunction

	function automatic instr_word_t random_legal(input int grp);	// 3 picks any group
		logic [5:0] opc;
		int         g;
		g = (grp == 3) ? next_rand(3) : grp;
		case (g)
			0:       opc = logic_ops[next_rand(6)];
			1:       opc = arith_ops[next_rand(4)];
			default: opc = cmp_ops[next_rand(2)];
		endcase
		if (opc[5:3] == 3'o6)
			return short_word(opc, 1 + next_rand(7), next_rand(127) - 63);
		return normal_word(opc, 1 + next_rand(7), 1 + next_rand(7));
	endfunction

	task automatic random_illegal(output instr_word_t w, output logic u);
		logic [5:0] opc;
		u = 1'b0;
		w = normal_word(norm_ops[next_rand(9)], next_rand(8), 1 + next_rand(7));
		case (next_rand(6))
			0: w.fmt_normal.rc = 3'd0;	// Would need an argument word
			1: w.fmt_normal.d = 1'b1;
			2: w.fmt_normal.rb = 3'(1 + next_rand(7));
			3: begin
				do
					opc = 6'(next_rand(64));
				while (opc inside {OP_LW, OP_AW, OP_AC, OP_SW, OP_CW, OP_OR, OP_NR, OP_ER,
					OP_XR, OP_AWT, OP_CWT, OP_LWT, OP_S});
				w.fmt_normal.opcode = opc;
			end
			4: begin
				w = normal_word(OP_S, 0, 0);	// HLT from user mode
				u = 1'b1;
			end
			default: w = normal_word(OP_S, 1 + next_rand(7), 0);	// S group with A not 0
		endcase
	endtask

	// Register and flag model with one record per issued word
	task automatic predict(input instr_word_t w, input logic u);
		result_rec_t r;
		logic [5:0]  opc;
		logic [2:0]  ra;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] s;
		logic [16:0] sum;
		int          sr;	// Exact signed result
		flags_t      f;
		logic        legal;
		if (mhalted)
			return;	// Never issued after HLT
		opc   = w.fmt_normal.opcode;
		ra    = w.fmt_normal.ra;
		a     = reg_value(ra);
		s     = a;
		f     = mflags;
		legal = opc inside {OP_LW, OP_AW, OP_AC, OP_SW, OP_CW, OP_OR, OP_NR, OP_ER, OP_XR,
			OP_AWT, OP_CWT, OP_LWT};
		if (opc[5:3] == 3'o6) begin	// T is sign and magnitude
			b = {10'd0, w.fmt_short.t_mag};
			if (w.fmt_short.t_sign)
				b = -b;
		end else begin
			b = reg_value(w.fmt_normal.rc);
			if (w.fmt_normal.d || w.fmt_normal.rb != 3'd0 || w.fmt_normal.rc == 3'd0)
				legal = 1'b0;
		end
		r.kind = REC_WRITE;
		if (opc == OP_S)
			r.kind = (ra == 3'd0 && !u) ? REC_HALT : REC_ILLEGAL;
		else if (!legal)
			r.kind = REC_ILLEGAL;
		else begin
			case (opc)
				OP_LW, OP_LWT: s = b;
				OP_SW: begin
					s   = a - b;
					sr  = int'($signed(a)) - int'($signed(b));
					f.c = (a < b);	// Borrow
					f.v = (sr < -32768) || (sr > 32767);
				end
				OP_AW, OP_AWT, OP_AC: begin
					sum = {1'b0, a} + {1'b0, b} + 17'((opc == OP_AC) ? f.c : 1'b0);
					sr  = int'($signed(a)) + int'($signed(b))
						+ int'((opc == OP_AC) ? f.c : 1'b0);
					s   = sum[15:0];
					f.c = sum[16];
					f.v = (sr < -32768) || (sr > 32767);	// Out of 16-bit signed range
				end
				OP_OR: s = a | b;
				OP_NR: s = a & b;
				OP_ER: s = a & ~b;
				OP_XR: s = a ^ b;
				default: begin	// CW and CWT
					r.kind = REC_FLAGS;
					f.l    = $signed(a) < $signed(b);
					f.e    = (a == b);
					f.g    = $signed(a) > $signed(b);
				end
			endcase
			if (r.kind == REC_WRITE) begin
				f.z = (s == 16'd0);
				f.m = s[15];
			end
		end
		if (r.kind == REC_WRITE && ra == 3'd0) begin
			f = flags_t'(s[6:0]);	// Write to R0 replaces flags
			s = {9'd0, s[6:0]};
		end else if (r.kind == REC_WRITE) begin
			mregs[ra] = s;
		end
		mflags  = f;
		mhalted = (r.kind == REC_HALT);
		r.ra    = ra;
		r.value = s;
		r.flags = f;
		exp_q.push_back(r);
	endtask

	task automatic fail_value(input string name, input logic [15:0] got, input logic [15:0] want);
		$display("FAIL %s: got %h, expected %h", name, got, want);
		err_cnt++;
	endtask

	task automatic send_word(input instr_word_t w, input logic u);
		@(posedge clk_sys);
		while (sent - credits_back >= IN_DEPTH) begin	// No input credit left
			instr_valid <= 1'b0;
			@(posedge clk_sys);
		end
		instr_valid <= 1'b1;
		instr       <= w;
		user_mode   <= u;
		sent++;
		predict(w, u);
	endtask

	task automatic end_burst();
		@(posedge clk_sys);
		instr_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int c;
		c = 0;
		while (exp_q.size() != 0 && c < DRAIN_CYCLES) begin
			@(posedge clk_sys);
			c++;
		end
		assert (exp_q.size() == 0)
		else begin
			$display("%0d predicted records never left the core", exp_q.size());
			err_cnt++;
		end
		repeat (8) @(posedge clk_sys);	// Room for a stray duplicate
	endtask

	task automatic start_test();
		err0 = err_cnt;
		rec0 = rec_cnt;
	endtask

	task automatic finish_test(input string name);
		end_burst();
		wait_drain();
		tests++;
		$display("test %0d %s: %0d records, %0d errors", tests, name, rec_cnt - rec0,
			err_cnt - err0);
	endtask

	// Input credits and the receiver's credit return
	always @(posedge clk_sys) begin
		logic [31:0] draw;
		if (!rst_n) begin
			credits_back <= 0;
			res_credit   <= 1'b0;
			owed = 0;
		end else begin
			draw = lcg_step(rx_seed);
			if (instr_credit)
				credits_back <= credits_back + 1;
			if (res_valid)
				owed++;
			if (owed > 0 && (!bp_mode || draw[31:30] == 2'd0)) begin	// Quarter rate under back-pressure
				res_credit <= 1'b1;
				owed--;
			end else begin
				res_credit <= 1'b0;
			end
		end
	end

	// Scoreboard samples outputs mid-cycle
	always @(negedge clk_sys) begin
		result_rec_t want;
		if (rst_n && res_valid) begin
			rec_cnt++;
			assert (exp_q.size() != 0)
			else begin
				$display("Record of kind %0d left the core with none predicted", res.kind);
				err_cnt++;
			end
			if (exp_q.size() != 0) begin
				want = exp_q.pop_front();
				assert (res.kind == want.kind)
					else fail_value("res.kind", 16'(res.kind), 16'(want.kind));
				assert (res.ra == want.ra) else fail_value("res.ra", 16'(res.ra), 16'(want.ra));
				assert (res.value == want.value) else fail_value("res.value", res.value, want.value);
				assert (res.flags == want.flags)
					else fail_value("res.flags", 16'(res.flags), 16'(want.flags));
				if (want.kind == REC_FLAGS) begin
					assert ($onehot({res.flags.l, res.flags.e, res.flags.g}))
						else fail_value("res.flags", 16'(res.flags), 16'(want.flags));
				end
			end
		end
		if (quiet) begin
			assert (halted)
			else begin
				$display("halted went low while the core was stopped");
				err_cnt++;
			end
			assert (!instr_credit)
			else begin
				$display("instr_credit was returned after the halt");
				err_cnt++;
			end
		end
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, %0d records outstanding", WD_CYCLES,
			exp_q.size());
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		instr_word_t w;
		logic        u;
		int          i;
		rst_n       = 1'b0;
		user_mode   = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		res_credit  = 1'b0;
		bp_mode     = 1'b0;
		quiet       = 1'b0;
		sent        = 0;
		err_cnt     = 0;
		rec_cnt     = 0;
		tests       = 0;
		mhalted     = 1'b0;
		mflags      = '0;
		for (int k = 1; k <= 7; k++)
			mregs[k] = 16'd0;
		repeat (10) @(posedge clk_sys);
		rst_n <= 1'b1;

		start_test();
		for (i = 0; i < N_RAND; i++)
			send_word(random_legal(0), 1'b0);
		finish_test("loads and logic");

		start_test();
		send_word(short_word(OP_LWT, 1, 1), 1'b0);
		repeat (15)
			send_word(normal_word(OP_AW, 1, 1), 1'b0);	// Doubles up to 0x8000
		send_word(short_word(OP_LWT, 2, 1), 1'b0);
		send_word(normal_word(OP_SW, 1, 2), 1'b0);	// 0x8000-1 overflows
		send_word(short_word(OP_AWT, 1, 1), 1'b0);	// 0x7FFF+1
		send_word(short_word(OP_LWT, 3, 0), 1'b0);
		send_word(normal_word(OP_SW, 3, 2), 1'b0);	// 0x0000-1 borrows
		send_word(normal_word(OP_AC, 4, 3), 1'b0);	// Carry chain
		send_word(normal_word(OP_AC, 4, 3), 1'b0);
		for (i = 0; i < N_RAND; i++)
			send_word(random_legal(1), 1'b0);
		finish_test("arithmetic flags");

		start_test();
		send_word(normal_word(OP_CW, 5, 5), 1'b0);	// Equal case
		for (i = 0; i < N_RAND; i++) begin
			w = random_legal(2);
			send_word(w, 1'b0);
			send_word(normal_word(OP_OR, w.fmt_normal.ra, w.fmt_normal.ra), 1'b0);	// Reads A back
		end
		finish_test("compare");

		start_test();
		for (i = 0; i < N_RAND; i++) begin
			random_illegal(w, u);
			send_word(w, u);
			send_word(random_legal(3), 1'b0);
		end
		finish_test("illegal words");

		start_test();
		bp_mode <= 1'b1;
		for (i = 0; i < N_RAND; i++) begin
			if (next_rand(5) == 0) begin
				random_illegal(w, u);
				send_word(w, u);
			end else begin
				send_word(random_legal(3), 1'b0);
			end
		end
		finish_test("credit back-pressure");
		bp_mode <= 1'b0;

		start_test();
		for (i = 0; i < 8; i++)
			send_word(random_legal(3), 1'b0);
		send_word(normal_word(OP_S, 0, 0), 1'b0);	// HLT in system mode
		while (sent - credits_back < IN_DEPTH)
			send_word(random_legal(3), 1'b0);	// Swallowed by the stopped decoder
		end_burst();
		wait_drain();
		quiet = 1'b1;
		repeat (40) @(posedge clk_sys);
		quiet = 1'b0;
		finish_test("halt");

		$display("%0d tests, %0d words sent, %0d records, %0d check errors, %0d property failures",
			tests, sent, rec_cnt, err_cnt, dut_i.props_i.fail_cnt);
		if (err_cnt == 0 && dut_i.props_i.fail_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- verilog/alu_execute.sv
// Execute stage. Holds r1-r7 and the R0 flags, runs the ALU on one decoded
// op at a time and emits a result record per op. Sends records only while it
// holds queue credits and returns its single slot credit to decode.

`timescale 1ns/10ps

module alu_execute #(
	parameter int RES_DEPTH = 4
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 op_valid,
	input  cpu_pkg::decoded_op_t op,
	output logic                 exe_credit,
	input  logic                 q_credit,
	output logic                 rec_valid,
	output cpu_pkg::result_rec_t rec
);

	import cpu_pkg::*;

	localparam int QCW = $clog2(RES_DEPTH + 1);

	logic [15:0]    regs [1:7];	// General registers
	flags_t         r0;
	decoded_op_t    slot_op;	// Op waiting for a queue credit
	logic           slot_valid;
	decoded_op_t    cur;
	logic           fire;
	logic [QCW-1:0] q_cnt;
	logic [15:0]    a;
	logic [15:0]    b;
	logic [15:0]    res;
	logic [16:0]    wide;	// Sum with carry out
	flags_t         fl;
	flags_t         fl_new;
	logic [15:0]    a_new;

	assign cur  = slot_valid ? slot_op : op;
	assign fire = (slot_valid || op_valid) && (q_cnt != '0);

	// Index 0 reads R0 zero-extended
	assign a = (cur.ra == 3'd0) ? {9'd0, r0} : regs[cur.ra];
	assign b = (cur.arg_src == ARG_SHORT) ? cur.short_arg :
		((cur.rc == 3'd0) ? {9'd0, r0} : regs[cur.rc]);

	always_comb begin
		fl   = r0;
		res  = a;
		wide = '0;
		case (cur.alu_op)
			ALU_LOAD: res = b;
			ALU_ADD:  wide = {1'b0, a} + {1'b0, b};
			ALU_ADC:  wide = {1'b0, a} + {1'b0, b} + {16'd0, r0.c};
			ALU_SUB:  wide = {1'b0, a} - {1'b0, b};	// Bit 16 is the borrow
			ALU_OR:   res = a | b;
			ALU_AND:  res = a & b;
			ALU_ANDN: res = a & ~b;
			ALU_XOR:  res = a ^ b;
			default:  res = a;	// Compare keeps A
		endcase
		if (cur.alu_op inside {ALU_ADD, ALU_ADC, ALU_SUB}) begin
			res  = wide[15:0];
			fl.c = wide[16];
			if (cur.alu_op == ALU_SUB)
				fl.v = (a[15] != b[15]) && (res[15] != a[15]);
			else
				fl.v = (a[15] == b[15]) && (res[15] != a[15]);
		end
		if (cur.alu_op == ALU_CMP) begin	// Exactly one of l, e, g
			fl.l = $signed(a) < $signed(b);
			fl.e = (a == b);
			fl.g = $signed(a) > $signed(b);
		end else begin
			fl.z = (res == 16'd0);
			fl.m = res[15];
		end
		if (!(cur.kind inside {REC_WRITE, REC_FLAGS})) begin
			fl  = r0;	// Illegal and HLT change nothing
			res = a;
		end
		fl_new = fl;
		a_new  = a;
		if (cur.writes_reg) begin
			if (cur.ra == 3'd0) begin
				fl_new = flags_t'(res[6:0]);	// Write to R0 replaces flags
				a_new  = {9'd0, res[6:0]};
			end else begin
				a_new = res;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			r0         <= '0;
			slot_valid <= 1'b0;
			rec_valid  <= 1'b0;
			exe_credit <= 1'b0;
			q_cnt      <= QCW'(RES_DEPTH);
			for (int i = 1; i <= 7; i++)
				regs[i] <= 16'd0;
		end else begin
			rec_valid  <= fire;
			exe_credit <= fire;	// Slot free again
			q_cnt      <= q_cnt + QCW'(q_credit) - QCW'(fire);
			if (fire) begin
				slot_valid <= 1'b0;
				r0         <= fl_new;
				if (cur.writes_reg && cur.ra != 3'd0)
					regs[cur.ra] <= a_new;
			end else if (op_valid) begin
				slot_valid <= 1'b1;	// No queue credit, park it
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (op_valid && !fire)
			slot_op <= op;
		if (fire)
			rec <= '{kind: cur.kind, ra: cur.ra, value: a_new, flags: fl_new};
	end

endmodule

//--- verilog/cpu_core.sv
// Top of the instruction core. Chains decode, execute and the result queue
// with their credit loops. Instructions enter on instr_valid with credits
// returned on instr_credit. Records leave on res_valid against res_credit.

`timescale 1ns/10ps

module cpu_core #(
	parameter int RES_DEPTH = 4	// Result queue slots
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 user_mode,
	input  logic                 instr_valid,
	input  cpu_pkg::instr_word_t instr,
	output logic                 instr_credit,
	output logic                 res_valid,
	output cpu_pkg::result_rec_t res,
	input  logic                 res_credit,
	output logic                 halted
);

	import cpu_pkg::*;

	logic        op_valid;
	decoded_op_t op;
	logic        exe_credit;	// Execute slot back to decode
	logic        rec_valid;
	result_rec_t rec;
	logic        q_credit;	// Queue slot back to execute

	instr_decode decode_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.user_mode    (user_mode),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.instr_credit (instr_credit),
		.exe_credit   (exe_credit),
		.op_valid     (op_valid),
		.op           (op),
		.halted       (halted)
	);

	alu_execute #(.RES_DEPTH(RES_DEPTH)) execute_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.op_valid   (op_valid),
		.op         (op),
		.exe_credit (exe_credit),
		.q_credit   (q_credit),
		.rec_valid  (rec_valid),
		.rec        (rec)
	);

	result_queue #(.RES_DEPTH(RES_DEPTH)) queue_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rec_valid  (rec_valid),
		.rec        (rec),
		.q_credit   (q_credit),
		.res_valid  (res_valid),
		.res        (res),
		.res_credit (res_credit)
	);

endmodule

//--- verilog/cpu_pkg.sv
// Shared definitions for the instruction core. Holds the two views of an
// instruction word, the opcodes of the kept subset, the R0 flags and the
// records passed between decode, execute and the result queue.
// Compile ahead of every other source.

package cpu_pkg;

	localparam int IN_DEPTH = 2;	// Decode input buffer slots, sender's starting credits

	// Normal-argument two-register group
	localparam logic [5:0] OP_LW  = 6'o20;
	localparam logic [5:0] OP_AW  = 6'o40;
	localparam logic [5:0] OP_AC  = 6'o41;
	localparam logic [5:0] OP_SW  = 6'o42;
	localparam logic [5:0] OP_CW  = 6'o43;
	localparam logic [5:0] OP_OR  = 6'o44;
	localparam logic [5:0] OP_NR  = 6'o46;
	localparam logic [5:0] OP_ER  = 6'o50;
	localparam logic [5:0] OP_XR  = 6'o52;
	// KA1 group, short argument
	localparam logic [5:0] OP_AWT = 6'o60;
	localparam logic [5:0] OP_CWT = 6'o64;
	localparam logic [5:0] OP_LWT = 6'o65;
	localparam logic [5:0] OP_S   = 6'o72;	// S group, HLT when A=0

	typedef struct packed {
		logic [5:0] opcode;
		logic       d;	// D-indirection
		logic [2:0] ra;
		logic [2:0] rb;	// B-modifier
		logic [2:0] rc;	// Argument register, 0 means next word
	} instr_normal_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic       t_sign;	// Sign of T
		logic [2:0] ra;
		logic [5:0] t_mag;	// Magnitude of T
	} instr_short_t;

	// One word, two field layouts picked by opcode group
	typedef union packed {
		instr_normal_t fmt_normal;
		instr_short_t  fmt_short;
	} instr_word_t;

	typedef enum logic [3:0] {
		ALU_LOAD,
		ALU_ADD,
		ALU_ADC,	// Add with carry from R0
		ALU_SUB,
		ALU_CMP,
		ALU_OR,
		ALU_AND,
		ALU_ANDN,	// ER clears bits of A
		ALU_XOR
	} alu_op_t;

	typedef enum logic {
		ARG_REG,	// From register C
		ARG_SHORT	// From field T
	} arg_src_t;

	typedef struct packed {
		logic z;
		logic m;
		logic v;
		logic c;
		logic l;
		logic e;
		logic g;
	} flags_t;

	typedef enum logic [1:0] {
		REC_WRITE,
		REC_FLAGS,	// Compare, flags only
		REC_ILLEGAL,
		REC_HALT
	} rec_kind_t;

	typedef struct packed {
		rec_kind_t   kind;
		alu_op_t     alu_op;
		arg_src_t    arg_src;
		logic [2:0]  ra;
		logic [2:0]  rc;
		logic [15:0] short_arg;	// T already as 16-bit value
		logic        writes_reg;
	} decoded_op_t;

	typedef struct packed {
		rec_kind_t   kind;
		logic [2:0]  ra;
		logic [15:0] value;	// Register A after the instruction
		flags_t      flags;
	} result_rec_t;

endpackage

//--- verilog/instr_decode.sv
// Decode stage. Buffers incoming words under credit control, holds the issued
// word in the instruction register and decodes it for execute. Issues only
// while it holds the single execute credit. Stops for good after HLT.

`timescale 1ns/10ps

module instr_decode (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 user_mode,
	input  logic                 instr_valid,
	input  cpu_pkg::instr_word_t instr,
	output logic                 instr_credit,
	input  logic                 exe_credit,
	output logic                 op_valid,
	output cpu_pkg::decoded_op_t op,
	output logic                 halted
);

	import cpu_pkg::*;

	localparam int IPW = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
	localparam int ICW = $clog2(IN_DEPTH + 1);

	typedef struct packed {
		logic        user;	// Mode the word arrived in
		instr_word_t word;
	} in_entry_t;

	in_entry_t      buf_mem [IN_DEPTH];
	logic [IPW-1:0] buf_rd;
	logic [IPW-1:0] buf_wr;
	logic [ICW-1:0] buf_cnt;
	in_entry_t      head;
	in_entry_t      ir;	// Instruction register
	logic           exe_cred;	// At most one op in execute
	logic           have;
	logic           issue;
	logic           bypass;
	logic           push;
	logic           stop;
	logic [5:0]     opc;
	logic           short_fmt;
	logic           norm_bad;
	logic [15:0]    t_val;

	function automatic logic [IPW-1:0] next_ptr(input logic [IPW-1:0] p);
		return (p == IPW'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign head   = (buf_cnt == '0) ? '{user: user_mode, word: instr} : buf_mem[buf_rd];
	assign have   = (buf_cnt != '0) || instr_valid;
	assign stop   = halted || (op_valid && op.kind == REC_HALT);	// HLT in flight blocks too
	assign issue  = have && (exe_cred || exe_credit) && !stop;
	assign bypass = issue && (buf_cnt == '0);	// Word goes straight to IR
	assign push   = instr_valid && !bypass;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			buf_rd       <= '0;
			buf_wr       <= '0;
			buf_cnt      <= '0;
			exe_cred     <= 1'b1;
			op_valid     <= 1'b0;
			instr_credit <= 1'b0;
			halted       <= 1'b0;
		end else begin
			op_valid     <= issue;
			instr_credit <= issue;	// One pulse per freed slot
			exe_cred     <= (exe_cred | exe_credit) & ~issue;
			buf_cnt      <= buf_cnt + ICW'(push) - ICW'(issue && !bypass);
			if (push)
				buf_wr <= next_ptr(buf_wr);
			if (issue && !bypass)
				buf_rd <= next_ptr(buf_rd);
			if (op_valid && op.kind == REC_HALT)
				halted <= 1'b1;	// Held until reset
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push)
			buf_mem[buf_wr] <= '{user: user_mode, word: instr};
		if (issue)
			ir <= head;
	end

	assign opc       = ir.word.fmt_normal.opcode;
	assign short_fmt = (opc[5:3] == 3'o6);	// KA1 group 060-067
	assign norm_bad  = ir.word.fmt_normal.d || (ir.word.fmt_normal.rb != 3'd0)
		|| (ir.word.fmt_normal.rc == 3'd0);
	assign t_val     = {10'd0, ir.word.fmt_short.t_mag};

	always_comb begin
		op            = '0;
		op.kind       = REC_WRITE;
		op.alu_op     = ALU_LOAD;
		op.arg_src    = short_fmt ? ARG_SHORT : ARG_REG;
		op.ra         = ir.word.fmt_normal.ra;	// Same bits in both formats
		op.rc         = ir.word.fmt_normal.rc;
		op.short_arg  = ir.word.fmt_short.t_sign ? -t_val : t_val;	// T is sign and magnitude
		case (opc)
			OP_LW, OP_LWT: op.alu_op = ALU_LOAD;
			OP_AW, OP_AWT: op.alu_op = ALU_ADD;
			OP_AC:         op.alu_op = ALU_ADC;
			OP_SW:         op.alu_op = ALU_SUB;
			OP_OR:         op.alu_op = ALU_OR;
			OP_NR:         op.alu_op = ALU_AND;
			OP_ER:         op.alu_op = ALU_ANDN;
			OP_XR:         op.alu_op = ALU_XOR;
			OP_CW, OP_CWT: begin
				op.alu_op = ALU_CMP;
				op.kind   = REC_FLAGS;
			end
			OP_S: begin	// Only HLT in system mode is kept
				if (ir.word.fmt_normal.ra == 3'd0 && !ir.user)
					op.kind = REC_HALT;
				else
					op.kind = REC_ILLEGAL;
			end
			default: op.kind = REC_ILLEGAL;
		endcase
		if (!short_fmt && opc != OP_S && norm_bad)
			op.kind = REC_ILLEGAL;	// No next word, indirection or modifier here
		op.writes_reg = (op.kind == REC_WRITE);
	end

endmodule

//--- verilog/result_queue.sv
// Result queue. Circular FIFO of RES_DEPTH records between execute and the
// outside. Sends the head record only while it holds an output credit and
// returns a credit to execute for every record that leaves.

`timescale 1ns/10ps

module result_queue #(
	parameter int RES_DEPTH = 4
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 rec_valid,
	input  cpu_pkg::result_rec_t rec,
	output logic                 q_credit,
	output logic                 res_valid,
	output cpu_pkg::result_rec_t res,
	input  logic                 res_credit
);

	import cpu_pkg::*;

	localparam int PW = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
	localparam int CW = $clog2(RES_DEPTH + 1);

	result_rec_t   mem [RES_DEPTH];
	logic [PW-1:0] rd_ptr;
	logic [PW-1:0] wr_ptr;
	logic [CW-1:0] count;	// Records held
	logic [CW-1:0] out_cnt;	// Receiver credits
	result_rec_t   head;
	logic          pop;
	logic          bypass;
	logic          push;

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
		return (p == PW'(RES_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign head   = (count == '0) ? rec : mem[rd_ptr];
	assign pop    = ((count != '0) || rec_valid) && (out_cnt != '0);
	assign bypass = pop && (count == '0);	// Empty queue, record passes through
	assign push   = rec_valid && !bypass;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rd_ptr    <= '0;
			wr_ptr    <= '0;
			count     <= '0;
			out_cnt   <= CW'(RES_DEPTH);
			res_valid <= 1'b0;
			q_credit  <= 1'b0;
		end else begin
			res_valid <= pop;
			q_credit  <= pop;	// Slot back to execute
			out_cnt   <= out_cnt + CW'(res_credit) - CW'(pop);
			count     <= count + CW'(push) - CW'(pop && !bypass);
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop && !bypass)
				rd_ptr <= next_ptr(rd_ptr);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push)
			mem[wr_ptr] <= rec;
		if (pop)
			res <= head;
	end

endmodule
